// File: source/bgPkg.sv
package bgPkg;

    ////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////

    // x and y width
    localparam int coordW = 10;
    // sky rows end here
    localparam logic [coordW-1:0] skyEnd = 10'd300;
    // first ground row
    localparam logic [coordW-1:0] groundStart = 10'd428;

    ////////////////////////////////////////
    // palette index layout
    ////////////////////////////////////////

    // bank on top, entry below
    localparam int bankW = 4;
    localparam int entryW = 5;
    localparam int indexW = bankW + entryW;

    localparam logic [bankW-1:0] bgBank = 4'd0;
    localparam logic [bankW-1:0] spriteBank = 4'd1;

    localparam logic [entryW-1:0] skyEntry = 5'd5;
    localparam logic [entryW-1:0] groundEntry = 5'd7;
    // sprite entry that lets the background through
    localparam logic [entryW-1:0] transparentEntry = 5'd0;

    ////////////////////////////////////////
    // background vram
    ////////////////////////////////////////

    localparam int vramAddrW = 11;
    localparam int vramDepth = 1 << vramAddrW;
    // three grass codes per word
    localparam int grassW = 3;
    localparam int grassCodes = 3;
    // enough for x div 3 over a full line
    localparam int groupW = 8;

    // grass view for the filler, raw view for the write port
    // leftmost pixel sits in grass[2]
    typedef union packed {
        logic [grassCodes-1:0][grassW-1:0] grass;
        logic [grassCodes*grassW-1:0] raw;
    } bgWordT;

    // pixel in to palette index out
    localparam int pipeLatency = 3;

endpackage

// File: source/bgVram.sv
module bgVram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [bgPkg::vramAddrW-1:0] wrAddr,
    input  bgPkg::bgWordT               wrData,
    input  logic [bgPkg::vramAddrW-1:0] rdAddr,
    output bgPkg::bgWordT               rdData
);

    import bgPkg::*;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // plain array so it maps onto block ram
    bgWordT mem [0:vramDepth-1];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    // whole word written at once
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrAddr].raw <= wrData.raw;
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // registered read, one clock
    // same address written this cycle still reads the old word
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: source/bgFiller.sv
module bgFiller (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        pixelEn,
    input  logic [bgPkg::coordW-1:0]    x,
    input  logic [bgPkg::coordW-1:0]    y,
    output logic [bgPkg::vramAddrW-1:0] vramAddr,
    input  bgPkg::bgWordT               vramWord,
    output logic [bgPkg::indexW-1:0]    bgIndex
);

    import bgPkg::*;

    ////////////////////////////////////////
    // grass phase tracking
    ////////////////////////////////////////

    // phase walks 0 1 2, group steps after phase 2
    logic [1:0]        phaseQ;
    logic [groupW-1:0] groupQ;
    // phase and group for the pixel on the inputs now
    logic [1:0]        curPhase;
    logic [groupW-1:0] curGroup;

    // x of zero starts a fresh line
    always_comb begin
        if (x == '0) begin
            curPhase = 2'd0;
            curGroup = '0;
        end else begin
            curPhase = phaseQ;
            curGroup = groupQ;
        end
    end

    // only enabled pixels move the scan position
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phaseQ <= 2'd0;
            groupQ <= '0;
        end else if (pixelEn) begin
            if (curPhase == 2'd2) begin
                phaseQ <= 2'd0;
                groupQ <= curGroup + 1'b1;
            end else begin
                phaseQ <= curPhase + 1'b1;
                groupQ <= curGroup;
            end
        end
    end

    ////////////////////////////////////////
    // stage 1 address and band
    ////////////////////////////////////////

    // row offset into the grass area plus group, wraps at 11 bits
    assign vramAddr = vramAddrW'(y) - vramAddrW'(skyEnd) + vramAddrW'(curGroup);

    // band and phase ride along with the vram read
    logic       skyQ;
    logic       groundQ;
    logic [1:0] phaseS1;

    always_ff @(posedge clk) begin
        skyQ    <= (y < skyEnd);
        groundQ <= (y >= groundStart);
        phaseS1 <= curPhase;
    end

    ////////////////////////////////////////
    // stage 2 index select
    ////////////////////////////////////////

    logic [grassW-1:0] grassCode;

    // phase 0 takes the top code
    always_comb begin
        case (phaseS1)
            2'd0:    grassCode = vramWord.grass[2];
            2'd1:    grassCode = vramWord.grass[1];
            2'd2:    grassCode = vramWord.grass[0];
            default: grassCode = vramWord.grass[2];
        endcase
    end

    always_ff @(posedge clk) begin
        if (skyQ) begin
            bgIndex <= {bgBank, skyEntry};
        end else if (groundQ) begin
            bgIndex <= {bgBank, groundEntry};
        end else begin
            // grass code fills the low entry bits
            bgIndex <= {bgBank, {(entryW-grassW){1'b0}}, grassCode};
        end
    end

endmodule

// File: source/spriteLayer.sv
module spriteLayer (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      pixelEn,
    input  logic [bgPkg::coordW-1:0]  x,
    input  logic [bgPkg::coordW-1:0]  y,
    input  logic                      spriteLoad,
    input  logic [bgPkg::coordW-1:0]  spriteX,
    input  logic [bgPkg::coordW-1:0]  spriteY,
    input  logic [bgPkg::coordW-1:0]  spriteW,
    input  logic [bgPkg::coordW-1:0]  spriteH,
    input  logic [bgPkg::entryW-1:0]  spriteFill,
    input  logic [bgPkg::entryW-1:0]  spriteEdge,
    output logic [bgPkg::indexW-1:0]  spriteIndex
);

    import bgPkg::*;

    ////////////////////////////////////////
    // sprite registers
    ////////////////////////////////////////

    logic [coordW-1:0] sprX;
    logic [coordW-1:0] sprY;
    logic [coordW-1:0] sprW;
    logic [coordW-1:0] sprH;
    logic [entryW-1:0] sprFill;
    logic [entryW-1:0] sprEdge;

    // zero width after reset keeps the sprite off
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sprX    <= '0;
            sprY    <= '0;
            sprW    <= '0;
            sprH    <= '0;
            sprFill <= transparentEntry;
            sprEdge <= transparentEntry;
        end else if (spriteLoad) begin
            sprX    <= spriteX;
            sprY    <= spriteY;
            sprW    <= spriteW;
            sprH    <= spriteH;
            sprFill <= spriteFill;
            sprEdge <= spriteEdge;
        end
    end

    ////////////////////////////////////////
    // stage 1 hit test
    ////////////////////////////////////////

    // one extra bit so the far edge cannot wrap
    logic [coordW:0] xEnd;
    logic [coordW:0] yEnd;
    logic            inX;
    logic            inY;
    logic            onBorder;

    assign xEnd = {1'b0, sprX} + {1'b0, sprW};
    assign yEnd = {1'b0, sprY} + {1'b0, sprH};

    assign inX = ({1'b0, x} >= {1'b0, sprX}) && ({1'b0, x} < xEnd);
    assign inY = ({1'b0, y} >= {1'b0, sprY}) && ({1'b0, y} < yEnd);

    // first and last row or column of the box
    assign onBorder = (x == sprX) || ({1'b0, x} == xEnd - 1'b1) ||
                      (y == sprY) || ({1'b0, y} == yEnd - 1'b1);

    logic [entryW-1:0] entryS1;
    logic [bankW-1:0]  bankS1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryS1 <= transparentEntry;
            bankS1  <= bgBank;
        end else if (pixelEn && inX && inY) begin
            entryS1 <= onBorder ? sprEdge : sprFill;
            bankS1  <= spriteBank;
        end else begin
            // outside the box, no sprite pixel
            entryS1 <= transparentEntry;
            bankS1  <= bgBank;
        end
    end

    ////////////////////////////////////////
    // stage 2 delay
    ////////////////////////////////////////

    // lines up with bgIndex from the filler
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            spriteIndex <= {bgBank, transparentEntry};
        end else begin
            spriteIndex <= {bankS1, entryS1};
        end
    end

endmodule

// File: source/layerMixer.sv
module layerMixer (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [bgPkg::indexW-1:0] bgIndex,
    input  logic [bgPkg::indexW-1:0] spriteIndex,
    input  logic                     validIn,
    output logic [bgPkg::indexW-1:0] pixelIndex,
    output logic                     indexValid
);

    import bgPkg::*;

    ////////////////////////////////////////
    // valid delay line
    ////////////////////////////////////////

    // stage 1 and stage 2 copies of pixelEn
    logic validS1;
    logic validS2;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validS1 <= 1'b0;
            validS2 <= 1'b0;
        end else begin
            validS1 <= validIn;
            validS2 <= validS1;
        end
    end

    ////////////////////////////////////////
    // priority select
    ////////////////////////////////////////

    logic spriteOpaque;

    // entry bits alone decide transparency
    assign spriteOpaque = (spriteIndex[entryW-1:0] != transparentEntry);

    // index only moves for real pixels
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixelIndex <= '0;
            indexValid <= 1'b0;
        end else begin
            indexValid <= validS2;
            if (validS2) begin
                pixelIndex <= spriteOpaque ? spriteIndex : bgIndex;
            end
        end
    end

endmodule

// File: source/sceneTop.sv
module sceneTop (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        pixelEn,
    input  logic [bgPkg::coordW-1:0]    x,
    input  logic [bgPkg::coordW-1:0]    y,
    input  logic                        vramWe,
    input  logic [bgPkg::vramAddrW-1:0] vramAddr,
    input  bgPkg::bgWordT               vramData,
    input  logic                        spriteLoad,
    input  logic [bgPkg::coordW-1:0]    spriteX,
    input  logic [bgPkg::coordW-1:0]    spriteY,
    input  logic [bgPkg::coordW-1:0]    spriteW,
    input  logic [bgPkg::coordW-1:0]    spriteH,
    input  logic [bgPkg::entryW-1:0]    spriteFill,
    input  logic [bgPkg::entryW-1:0]    spriteEdge,
    output logic [bgPkg::indexW-1:0]    pixelIndex,
    output logic                        indexValid
);

    import bgPkg::*;

    ////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////

    // filler read address and returned word
    logic [vramAddrW-1:0] rdAddr;
    bgWordT               rdWord;
    // layer outputs, both at stage 2
    logic [indexW-1:0]    bgIndex;
    logic [indexW-1:0]    spriteIndex;

    ////////////////////////////////////////
    // background path
    ////////////////////////////////////////

    bgFiller u_bgFiller (
        .clk      (clk),
        .rstN     (rstN),
        .pixelEn  (pixelEn),
        .x        (x),
        .y        (y),
        .vramAddr (rdAddr),
        .vramWord (rdWord),
        .bgIndex  (bgIndex)
    );

    // write side comes straight from the top ports
    bgVram u_bgVram (
        .clk    (clk),
        .we     (vramWe),
        .wrAddr (vramAddr),
        .wrData (vramData),
        .rdAddr (rdAddr),
        .rdData (rdWord)
    );

    ////////////////////////////////////////
    // sprite path
    ////////////////////////////////////////

    spriteLayer u_spriteLayer (
        .clk         (clk),
        .rstN        (rstN),
        .pixelEn     (pixelEn),
        .x           (x),
        .y           (y),
        .spriteLoad  (spriteLoad),
        .spriteX     (spriteX),
        .spriteY     (spriteY),
        .spriteW     (spriteW),
        .spriteH     (spriteH),
        .spriteFill  (spriteFill),
        .spriteEdge  (spriteEdge),
        .spriteIndex (spriteIndex)
    );

    ////////////////////////////////////////
    // output stage
    ////////////////////////////////////////

    // pixelEn doubles as the valid input
    layerMixer u_layerMixer (
        .clk         (clk),
        .rstN        (rstN),
        .bgIndex     (bgIndex),
        .spriteIndex (spriteIndex),
        .validIn     (pixelEn),
        .pixelIndex  (pixelIndex),
        .indexValid  (indexValid)
    );

endmodule

// File: tb/sceneTop_sva.sv
module sceneTop_sva (
    input logic                     clk,
    input logic                     rstN,
    input logic [bgPkg::indexW-1:0] pixelIndex,
    input logic                     indexValid
);

    import bgPkg::*;

    // reset cycle itself plus the three that follow
    localparam int quietCycles = pipeLatency + 1;

    logic [bankW-1:0] bank;

    assign bank = pixelIndex[indexW-1:entryW];

    quietAfterReset: assert property (@(posedge clk)
        !rstN |-> !indexValid [*quietCycles])
        else $error("indexValid high during or just after reset");

    bankLegal: assert property (@(posedge clk) disable iff (!rstN)
        indexValid |-> (bank == bgBank || bank == spriteBank))
        else $error("pixelIndex bank %0d is neither background nor sprite", bank);

    indexKnown: assert property (@(posedge clk) disable iff (!rstN)
        indexValid |-> !$isunknown(pixelIndex))
        else $error("pixelIndex has unknown bits while valid");

endmodule

bind sceneTop sceneTop_sva u_sceneTopSva (
    .clk        (clk),
    .rstN       (rstN),
    .pixelIndex (pixelIndex),
    .indexValid (indexValid)
);

// File: tb/sceneChecker.sv
module sceneChecker (
    input  logic                     clk,
    input  logic                     expValid,
    input  logic [bgPkg::indexW-1:0] expIndex,
    input  logic [bgPkg::indexW-1:0] pixelIndex,
    input  logic                     indexValid,
    output int                       errorCount,
    output int                       checkCount
);

    import bgPkg::*;

    ////////////////////////////////////////
    // expected value delay
    ////////////////////////////////////////

    // valid flag on top, index below
    logic [indexW:0] pending [$];
    logic [indexW:0] due = '0;
    logic            dueValid;
    logic [indexW-1:0] dueIndex;

    assign dueValid = due[indexW];
    assign dueIndex = due[indexW-1:0];

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    // sampled on the rising edge, one entry per clock
    always @(posedge clk) begin
        pending.push_back({expValid, expIndex});
        if (pending.size() >= pipeLatency) begin
            due = pending.pop_front();
        end else begin
            due = '0;
        end
    end

    ////////////////////////////////////////
    // compare
    ////////////////////////////////////////

    // outputs settle after the rising edge, so look on the falling one
    always @(negedge clk) begin
        // every valid output from the dut counts, expected or not
        if (indexValid === 1'b1) begin
            checkCount++;
        end
        if (!dueValid && indexValid !== 1'b0) begin
            $display("time %0t: indexValid high with no pixel pending", $time);
            errorCount++;
        end else if (dueValid) begin
            if (indexValid !== 1'b1) begin
                $display("Mismatch at time %0t: indexValid expected 1, got %b",
                         $time, indexValid);
                errorCount++;
            end else if (pixelIndex !== dueIndex) begin
                $display("Mismatch at time %0t: pixelIndex expected 0x%03h, got 0x%03h",
                         $time, dueIndex, pixelIndex);
                errorCount++;
            end
        end
    end

endmodule

// File: tb/sceneTb.sv
module sceneTb;

    import bgPkg::*;

    localparam int resetCycles = 16;
    localparam int marginCycles = 20;
    localparam int lineW = 8 * 96;
    localparam int nameW = 8 * 32;

    ////////////////////////////////////////
    // dut signals
    ////////////////////////////////////////

    logic                 clk;
    logic                 rstN;
    logic                 pixelEn;
    logic [coordW-1:0]    x;
    logic [coordW-1:0]    y;
    logic                 vramWe;
    logic [vramAddrW-1:0] vramAddr;
    bgWordT               vramData;
    logic                 spriteLoad;
    logic [coordW-1:0]    spriteX;
    logic [coordW-1:0]    spriteY;
    logic [coordW-1:0]    spriteW;
    logic [coordW-1:0]    spriteH;
    logic [entryW-1:0]    spriteFill;
    logic [entryW-1:0]    spriteEdge;
    logic [indexW-1:0]    pixelIndex;
    logic                 indexValid;

    // expected side, handed to the checker with each pixel
    logic              expValid;
    logic [indexW-1:0] expIndex;
    int                errorCount;
    int                checkCount;

    // records from the vectors file, one entry per line
    logic [7:0]       recKind [$];
    logic [nameW-1:0] recName [$];
    int recA [$];
    int recB [$];
    int recC [$];
    int recD [$];
    int recE [$];
    int recF [$];

    int               cycleCount = 0;
    int               cycleLimit = 0;
    int               numTests = 0;
    int               pixelsSent = 0;
    int               testErrStart = 0;
    logic             testOpen = 1'b0;
    logic [nameW-1:0] curName;

    ////////////////////////////////////////
    // dut and checker
    ////////////////////////////////////////

    sceneTop u_sceneTop (
        .clk        (clk),
        .rstN       (rstN),
        .pixelEn    (pixelEn),
        .x          (x),
        .y          (y),
        .vramWe     (vramWe),
        .vramAddr   (vramAddr),
        .vramData   (vramData),
        .spriteLoad (spriteLoad),
        .spriteX    (spriteX),
        .spriteY    (spriteY),
        .spriteW    (spriteW),
        .spriteH    (spriteH),
        .spriteFill (spriteFill),
        .spriteEdge (spriteEdge),
        .pixelIndex (pixelIndex),
        .indexValid (indexValid)
    );

    sceneChecker u_checker (
        .clk        (clk),
        .expValid   (expValid),
        .expIndex   (expIndex),
        .pixelIndex (pixelIndex),
        .indexValid (indexValid),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    ////////////////////////////////////////
    // clock and watchdog
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // limit is set once the vectors are loaded
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleCount);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // strobes low and buses parked at zero
    task automatic clearInputs();
        pixelEn    = 1'b0;
        x          = '0;
        y          = '0;
        vramWe     = 1'b0;
        vramAddr   = '0;
        vramData   = '0;
        spriteLoad = 1'b0;
        spriteX    = '0;
        spriteY    = '0;
        spriteW    = '0;
        spriteH    = '0;
        spriteFill = '0;
        spriteEdge = '0;
        expValid   = 1'b0;
        expIndex   = '0;
    endtask

    task automatic readVectors(output logic ok);
        int               fd;
        int               n;
        int               a;
        int               b;
        int               c;
        int               d;
        int               e;
        int               f;
        logic [lineW-1:0] line;
        logic [63:0]      kind;
        logic [nameW-1:0] name;
        ok = 1'b0;
        fd = $fopen("tb/sceneVectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = '0;
                kind = '0;
                name = '0;
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                e = 0;
                f = 0;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", kind);
                end
                // comment and blank lines fall through to default
                case (kind)
                    "T": n = $sscanf(line, "%s %s", kind, name);
                    "W": n = $sscanf(line, "%s %d %h", kind, a, b);
                    "L": n = $sscanf(line, "%s %d %d %d %d %d %d", kind, a, b, c, d, e, f);
                    "P": n = $sscanf(line, "%s %d %d %h", kind, a, b, c);
                    default: kind = '0;
                endcase
                if (kind != '0) begin
                    recKind.push_back(kind[7:0]);
                    recName.push_back(name);
                    recA.push_back(a);
                    recB.push_back(b);
                    recC.push_back(c);
                    recD.push_back(d);
                    recE.push_back(e);
                    recF.push_back(f);
                    if (kind == "T") begin
                        numTests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // drive one record, called right after a falling edge
    task automatic applyRecord(input int i);
        clearInputs();
        case (recKind[i])
            "W": begin
                vramWe       = 1'b1;
                vramAddr     = vramAddrW'(recA[i]);
                vramData.raw = indexW'(recB[i]);
            end
            "L": begin
                spriteLoad = 1'b1;
                spriteX    = coordW'(recA[i]);
                spriteY    = coordW'(recB[i]);
                spriteW    = coordW'(recC[i]);
                spriteH    = coordW'(recD[i]);
                spriteFill = entryW'(recE[i]);
                spriteEdge = entryW'(recF[i]);
            end
            "P": begin
                pixelEn  = 1'b1;
                x        = coordW'(recA[i]);
                y        = coordW'(recB[i]);
                expValid = 1'b1;
                expIndex = indexW'(recC[i]);
                pixelsSent++;
            end
            default: ;
        endcase
    endtask

    // idle until the last pixel has been compared
    task automatic drainPipe();
        repeat (pipeLatency) begin
            @(negedge clk);
            clearInputs();
        end
        @(posedge clk);
    endtask

    task automatic reportTest(input logic [nameW-1:0] name, input int errs);
        $display("test %0s: %0d error(s)", name, errs);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    logic loaded;
    logic runFailed;

    initial begin
        clearInputs();
        rstN = 1'b0;
        readVectors(loaded);
        if (!loaded) begin
            $display("could not open tb/sceneVectors.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            // every marker drains the pipe, plus one final drain
            cycleLimit = resetCycles + (recKind.size() - numTests) +
                         (numTests + 1) * (pipeLatency + 1) + marginCycles;
            repeat (resetCycles) @(negedge clk);
            rstN = 1'b1;
            for (int i = 0; i < recKind.size(); i++) begin
                if (recKind[i] == "T") begin
                    drainPipe();
                    if (testOpen) begin
                        reportTest(curName, errorCount - testErrStart);
                    end
                    curName = recName[i];
                    testErrStart = errorCount;
                    testOpen = 1'b1;
                end else begin
                    @(negedge clk);
                    applyRecord(i);
                end
            end
            drainPipe();
            if (testOpen) begin
                reportTest(curName, errorCount - testErrStart);
            end
            runFailed = (errorCount != 0) || (checkCount != pixelsSent);
            if (checkCount != pixelsSent) begin
                $display("output count wrong: %0d pixels sent, %0d outputs checked",
                         pixelsSent, checkCount);
            end
            $display("totals: %0d tests, %0d pixels, %0d errors",
                     numTests, checkCount, errorCount);
            if (runFailed) begin
                $display("ERRORS FOUND");
            end else begin
                $display("NO ERRORS");
            end
            $finish;
        end
    end

endmodule

// File: tb/sceneVectors.txt
# T name | W addr(dec) data(hex) | L x y w h fill edge (all dec)
# P x y expectedIndex(hex), index is bank in bits 8:5 and entry in bits 4:0
T resetLatency
P 0 0 005
P 1 0 005
P 2 0 005
P 639 479 007
T skyGroundBands
W 2047 1ff
W 128 000
P 0 299 005
P 5 299 005
P 0 428 007
P 100 479 007
T grassDecode
W 0 053
W 1 1ac
W 2 1c7
W 50 08e
W 51 111
P 0 300 001
P 1 300 002
P 2 300 003
P 3 300 006
P 4 300 005
P 5 300 004
P 6 300 007
P 7 300 000
P 8 300 007
P 0 350 002
P 1 350 001
P 2 350 006
P 3 350 004
P 4 350 002
P 5 350 001
T phaseRestart
P 0 300 001
P 1 300 002
P 0 301 006
P 1 301 005
P 2 301 004
P 3 301 007
T spritePriority
L 100 50 4 3 12 9
P 99 51 005
P 100 51 029
P 101 51 02c
P 102 51 02c
P 103 51 029
P 104 51 005
P 101 50 029
P 101 52 029
P 101 53 005
P 101 49 005
L 100 50 4 3 0 9
P 101 51 005
P 103 52 029
T writeTiming
W 10 0a5
P 0 310 002
W 10 1ff
P 1 310 007

// File: project.f
source/bgPkg.sv
source/bgVram.sv
source/bgFiller.sv
source/spriteLayer.sv
source/layerMixer.sv
source/sceneTop.sv
tb/sceneTop_sva.sv
tb/sceneChecker.sv
tb/sceneTb.sv
